// File: alu.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module alu
	import isa_pkg::*;
(
	input  opcode_e               opcode,
	input  func_e                 func_code,
	input  logic [`WORD_SIZE-1:0] alu_input_1,
	input  logic [`WORD_SIZE-1:0] alu_input_2,
	output logic [`WORD_SIZE-1:0] alu_result,
	output logic                  overflow_flag,
	output logic                  bcond
);

	logic                  sub_sel;
	logic [`WORD_SIZE-1:0] add_out;
	logic                  add_ovf;

	assign sub_sel = (opcode == ALU_OP) && (func_code == SUB);

	// Single adder serves ADD, SUB and all address/immediate adds
	alu_add_sub u_add_sub (
		.a        (alu_input_1),
		.b        (alu_input_2),
		.sub      (sub_sel),
		.sum      (add_out),
		.overflow (add_ovf)
	);

	always_comb begin
		alu_result = '0;
		overflow_flag = 1'b0;
		bcond = 1'b0;
		case (opcode)
			ALU_OP: begin
				case (func_code)
					ADD, SUB: begin
						alu_result = add_out;
						overflow_flag = add_ovf;
					end
					AND: alu_result = alu_input_1 & alu_input_2;
					ORR: alu_result = alu_input_1 | alu_input_2;
					NOT: alu_result = ~alu_input_1;
					TCP: alu_result = ~alu_input_1 + 1'b1;
					SHL: alu_result = {alu_input_1[`WORD_SIZE-2:0], 1'b0};
					SHR: alu_result = {alu_input_1[`WORD_SIZE-1], alu_input_1[`WORD_SIZE-1:1]};
					JPR, JRL, WWD: alu_result = alu_input_1;
					// HLT falls in here too
					default: alu_result = '0;
				endcase
			end

			// Only the branch condition comes from here and branch_unit forms the target
			BNE: bcond = (alu_input_1 != alu_input_2);
			BEQ: bcond = (alu_input_1 == alu_input_2);
			BGZ: bcond = ($signed(alu_input_1) > 0);
			BLZ: bcond = ($signed(alu_input_1) < 0);

			ADI, LWD, SWD: begin
				alu_result = add_out;
				overflow_flag = add_ovf;
			end
			ORI: alu_result = alu_input_1 | alu_input_2;
			LHI: alu_result = alu_input_2;

			default: begin
				alu_result = '0;
				overflow_flag = 1'b0;
				bcond = 1'b0;
			end
		endcase
	end

endmodule

// File: alu_add_sub.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module alu_add_sub (
	input  logic [`WORD_SIZE-1:0] a,
	input  logic [`WORD_SIZE-1:0] b,
	input  logic                  sub,
	output logic [`WORD_SIZE-1:0] sum,
	output logic                  overflow
);

	logic [`WORD_SIZE-1:0] b_eff;

	// Subtraction is a + ~b + 1 with the carry-in taken from sub
	assign b_eff = sub ? ~b : b;
	assign sum = a + b_eff + {{(`WORD_SIZE-1){1'b0}}, sub};

	// Same-sign operands whose sum flips sign
	assign overflow = (a[`WORD_SIZE-1] == b_eff[`WORD_SIZE-1]) &&
		(sum[`WORD_SIZE-1] != a[`WORD_SIZE-1]);

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module branch_unit
	import isa_pkg::*;
(
	input  logic [`WORD_SIZE-1:0] pc,
	input  instr_t                instr,
	input  logic [`WORD_SIZE-1:0] rs_val,
	input  logic [`WORD_SIZE-1:0] ext_imm,
	input  logic                  bcond,
	output logic                  taken,
	output logic [`WORD_SIZE-1:0] next_pc
);

	logic [`WORD_SIZE-1:0] pc_plus1;
	logic [`WORD_SIZE-1:0] branch_target;
	logic [`WORD_SIZE-1:0] jump_target;

	assign pc_plus1 = pc + 1'b1;
	assign branch_target = pc_plus1 + ext_imm;

	// Jumps stay inside the current 4K region
	assign jump_target = {pc[`WORD_SIZE-1:`JTARGET_W], jtarget_field(instr)};

	always_comb begin
		taken = 1'b0;
		next_pc = pc_plus1;
		case (instr.opcode)
			BNE, BEQ, BGZ, BLZ: begin
				if (bcond) begin
					taken = 1'b1;
					next_pc = branch_target;
				end
			end
			JMP, JAL: begin
				taken = 1'b1;
				next_pc = jump_target;
			end
			ALU_OP: begin
				if (instr.func == JPR || instr.func == JRL) begin
					taken = 1'b1;
					next_pc = rs_val;
				end
			end
			default: begin
				taken = 1'b0;
				next_pc = pc_plus1;
			end
		endcase
	end

endmodule

// File: exec_pkg.sv
`include "tsc_config.svh"

package exec_pkg;

	import isa_pkg::*;

	// Decode to execute
	typedef struct packed {
		logic                   valid;
		logic [`WORD_SIZE-1:0]  pc;
		instr_t                 instr;
		logic [`WORD_SIZE-1:0]  rs_val;
		logic [`WORD_SIZE-1:0]  rt_val;
	} id_ex_t;

	// Execute to memory
	typedef struct packed {
		logic                   valid;
		instr_t                 instr;
		logic [`WORD_SIZE-1:0]  result;
		logic                   overflow;
		logic [`WORD_SIZE-1:0]  store_data;
		logic                   redirect;
		logic [`WORD_SIZE-1:0]  next_pc;
	} ex_mem_t;

endpackage

// File: execute_assertions.sv
`timescale 1ns/1ps

module execute_assertions
	import isa_pkg::*;
	import exec_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    stall,
	input ex_mem_t ex_out,
	input logic    redirect,
	input logic    id_ex_valid,
	input instr_t  id_ex_instr
);

	// Both valid bits clear on every reset edge
	property valid_low_after_reset;
		@(posedge clk) rst |=> !ex_out.valid;
	endproperty

	property redirect_low_after_reset;
		@(posedge clk) rst |=> !redirect;
	endproperty

	// A stalled edge leaves the output register untouched
	property hold_on_stall;
		@(posedge clk) (!rst && stall) |=> $stable(ex_out);
	endproperty

	// Only a valid branch or jump in id_ex may steer fetch
	property redirect_needs_valid;
		@(posedge clk) redirect |-> id_ex_valid && (id_ex_instr.opcode inside
			{BNE, BEQ, BGZ, BLZ, JMP, JAL} || (id_ex_instr.opcode == ALU_OP &&
			id_ex_instr.func inside {JPR, JRL}));
	endproperty

	assert property (valid_low_after_reset)
		else $error("ex_out.valid high after a reset edge");
	assert property (redirect_low_after_reset)
		else $error("redirect high after a reset edge");
	assert property (hold_on_stall)
		else $error("ex_out changed across a stalled edge");
	assert property (redirect_needs_valid)
		else $error("redirect high without a valid branch or jump in id_ex");

endmodule

bind execute_stage execute_assertions u_execute_assertions (
	.clk         (clk),
	.rst         (rst),
	.stall       (stall),
	.ex_out      (ex_out),
	.redirect    (redirect),
	.id_ex_valid (id_ex_valid),
	.id_ex_instr (id_ex.instr)
);

// File: execute_stage.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module execute_stage
	import isa_pkg::*;
	import exec_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  id_ex_t                id_in,
	output ex_mem_t               ex_out,
	output logic                  redirect,
	output logic [`WORD_SIZE-1:0] next_pc
);

	id_ex_t                 id_ex;
	logic                   id_ex_valid;
	logic [`WORD_SIZE-1:0]  alu_b;
	logic [`WORD_SIZE-1:0]  ext_imm;
	logic [`WORD_SIZE-1:0]  alu_result;
	logic                   alu_ovf;
	logic                   bcond;
	logic                   taken;
	ex_mem_t                ex_mem_d;
	ex_mem_t                ex_mem_q;
	logic                   ex_mem_valid;

	pipe_stage #(.payload_t(id_ex_t)) u_id_ex (
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.d        (id_in),
		.valid_in (id_in.valid),
		.q        (id_ex),
		.valid    (id_ex_valid)
	);

	operand_gen u_operand_gen (
		.instr   (id_ex.instr),
		.rt_val  (id_ex.rt_val),
		.alu_b   (alu_b),
		.ext_imm (ext_imm)
	);

	alu u_alu (
		.opcode        (id_ex.instr.opcode),
		.func_code     (id_ex.instr.func),
		.alu_input_1   (id_ex.rs_val),
		.alu_input_2   (alu_b),
		.alu_result    (alu_result),
		.overflow_flag (alu_ovf),
		.bcond         (bcond)
	);

	branch_unit u_branch_unit (
		.pc      (id_ex.pc),
		.instr   (id_ex.instr),
		.rs_val  (id_ex.rs_val),
		.ext_imm (ext_imm),
		.bcond   (bcond),
		.taken   (taken),
		.next_pc (next_pc)
	);

	// Fetch sees the redirect in the same cycle the instruction sits in id_ex
	assign redirect = id_ex_valid & taken;

	assign ex_mem_d = '{
		valid:      id_ex_valid,
		instr:      id_ex.instr,
		result:     alu_result,
		overflow:   alu_ovf,
		store_data: id_ex.rt_val,
		redirect:   redirect,
		next_pc:    next_pc
	};

	pipe_stage #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.d        (ex_mem_d),
		.valid_in (ex_mem_d.valid),
		.q        (ex_mem_q),
		.valid    (ex_mem_valid)
	);

	// ex_out.valid follows the stage's own valid bit rather than the payload copy
	always_comb begin
		ex_out = ex_mem_q;
		ex_out.valid = ex_mem_valid;
	end

endmodule

// File: isa_pkg.sv
`include "tsc_config.svh"

package isa_pkg;

	// Major opcodes, top four bits of every instruction
	typedef enum logic [3:0] {
		BNE    = 4'd0,
		BEQ    = 4'd1,
		BGZ    = 4'd2,
		BLZ    = 4'd3,
		ADI    = 4'd4,
		ORI    = 4'd5,
		LHI    = 4'd6,
		LWD    = 4'd7,
		SWD    = 4'd8,
		JMP    = 4'd9,
		JAL    = 4'd10,
		ALU_OP = 4'd15
	} opcode_e;

	// Function codes, only meaningful under ALU_OP
	typedef enum logic [5:0] {
		ADD = 6'd0,
		SUB = 6'd1,
		AND = 6'd2,
		ORR = 6'd3,
		NOT = 6'd4,
		TCP = 6'd5,
		SHL = 6'd6,
		SHR = 6'd7,
		JPR = 6'd25,
		JRL = 6'd26,
		WWD = 6'd28,
		HLT = 6'd29
	} func_e;

	// R-format view; I-format and J-format reuse the low bits
	typedef struct packed {
		opcode_e                 opcode;
		logic [`REG_ADDR_W-1:0]  rs;
		logic [`REG_ADDR_W-1:0]  rt;
		logic [`REG_ADDR_W-1:0]  rd;
		func_e                   func;
	} instr_t;

	// The immediate spans rd and func
	function automatic logic [`IMM_W-1:0] imm_field(input instr_t i);
		logic [`WORD_SIZE-1:0] raw;
		raw = i;
		return raw[`IMM_W-1:0];
	endfunction

	// The jump target spans everything below the opcode
	function automatic logic [`JTARGET_W-1:0] jtarget_field(input instr_t i);
		logic [`WORD_SIZE-1:0] raw;
		raw = i;
		return raw[`JTARGET_W-1:0];
	endfunction

endpackage

// File: operand_gen.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module operand_gen
	import isa_pkg::*;
(
	input  instr_t                instr,
	input  logic [`WORD_SIZE-1:0] rt_val,
	output logic [`WORD_SIZE-1:0] alu_b,
	output logic [`WORD_SIZE-1:0] ext_imm
);

	logic [`IMM_W-1:0]      imm;
	logic [`WORD_SIZE-1:0]  zext_imm;
	logic [`WORD_SIZE-1:0]  high_imm;

	assign imm = imm_field(instr);

	// Branch offsets always use the sign-extended form
	assign ext_imm = {{(`WORD_SIZE-`IMM_W){imm[`IMM_W-1]}}, imm};
	assign zext_imm = {{(`WORD_SIZE-`IMM_W){1'b0}}, imm};
	assign high_imm = {imm, {(`WORD_SIZE-`IMM_W){1'b0}}};

	always_comb begin
		case (instr.opcode)
			ORI: alu_b = zext_imm;
			LHI: alu_b = high_imm;
			ADI, LWD, SWD: alu_b = ext_imm;
			default: alu_b = rt_val;
		endcase
	end

endmodule

// File: pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     stall,
	input  payload_t d,
	input  logic     valid_in,
	output payload_t q,
	output logic     valid
);

	// Only the valid bit is control state
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else if (!stall) begin
			valid <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			q <= d;
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_execute -o tb_execute
./obj_dir/tb_execute

// File: tb.f
+incdir+.
isa_pkg.sv
exec_pkg.sv
alu_add_sub.sv
alu.sv
operand_gen.sv
branch_unit.sv
pipe_stage.sv
execute_stage.sv
execute_assertions.sv
tb_execute.sv

// File: tb_execute.sv
`timescale 1ns/1ps
`include "tsc_config.svh"

module tb_execute
	import isa_pkg::*;
	import exec_pkg::*;
();

	localparam int NUM_INSTR = 300;
	localparam int MAX_CYCLES = 3000;
	localparam int DRAIN_LIMIT = 10;

	logic                  clk;
	logic                  rst;
	logic                  stall;
	id_ex_t                id_in;
	ex_mem_t               ex_out;
	logic                  redirect;
	logic [`WORD_SIZE-1:0] next_pc;

	integer     seed;
	id_ex_t     directed [$];
	ex_mem_t    exp_q [$];
	int         issue_q [$];
	id_ex_t     idex_m;
	logic       idex_valid_m = 1'b0;
	int         edge_count = 0;
	logic       ex_new = 1'b0;
	logic       rst_edge = 1'b0;
	logic       clocked = 1'b0;
	logic [5:0] func_pool [0:15] = '{6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7,
		6'd25, 6'd26, 6'd28, 6'd29, 6'd8, 6'd27, 6'd30, 6'd63};

	execute_stage dut (
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.id_in    (id_in),
		.ex_out   (ex_out),
		.redirect (redirect),
		.next_pc  (next_pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_problem(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		report_problem($sformatf("** Error: %s = %h, expected %h", name, got, exp));
	endtask

	function automatic int sval(input logic [15:0] x);
		return int'($signed(x));
	endfunction

	// Expected execute result, straight from the ISA rules
	function automatic ex_mem_t exec_ref(input id_ex_t id);
		ex_mem_t     e;
		logic [15:0] raw;
		logic [15:0] a;
		logic [15:0] simm;
		logic [15:0] pc1;
		int          wide;
		logic        cond;
		raw = id.instr;
		a = id.rs_val;
		simm = {{8{raw[7]}}, raw[7:0]};
		pc1 = id.pc + 16'd1;
		e = '0;
		e.valid = 1'b1;
		e.instr = id.instr;
		e.store_data = id.rt_val;
		e.next_pc = pc1;
		cond = 1'b0;
		wide = 0;
		case (opcode_e'(raw[15:12]))
			ALU_OP: begin
				case (func_e'(raw[5:0]))
					ADD: wide = sval(a) + sval(id.rt_val);
					SUB: wide = sval(a) - sval(id.rt_val);
					AND: e.result = a & id.rt_val;
					ORR: e.result = a | id.rt_val;
					NOT: e.result = ~a;
					TCP: e.result = 16'd0 - a;
					SHL: e.result = a << 1;
					SHR: e.result = 16'($signed(a) >>> 1);
					WWD: e.result = a;
					JPR, JRL: begin
						e.result = a;
						e.redirect = 1'b1;
						e.next_pc = a;
					end
					default: e.result = 16'd0;
				endcase
				if (raw[5:0] == 6'd0 || raw[5:0] == 6'd1) begin
					e.result = wide[15:0];
					e.overflow = (wide > 32767) || (wide < -32768);
				end
			end
			BNE: cond = a != id.rt_val;
			BEQ: cond = a == id.rt_val;
			BGZ: cond = sval(a) > 0;
			BLZ: cond = sval(a) < 0;
			ADI, LWD, SWD: begin
				wide = sval(a) + sval(simm);
				e.result = wide[15:0];
				e.overflow = (wide > 32767) || (wide < -32768);
			end
			ORI: e.result = a | {8'h00, raw[7:0]};
			LHI: e.result = {raw[7:0], 8'h00};
			JMP, JAL: begin
				e.redirect = 1'b1;
				e.next_pc = {id.pc[15:12], raw[11:0]};
			end
			default: e.result = 16'd0;
		endcase
		if (cond) begin
			e.redirect = 1'b1;
			e.next_pc = pc1 + simm;
		end
		return e;
	endfunction

	function automatic id_ex_t build_instr(input logic [3:0] op, input logic [7:0] low,
		input logic [15:0] pc, input logic [15:0] rs, input logic [15:0] rt);
		id_ex_t id;
		id.valid = 1'b1;
		id.pc = pc;
		id.instr = instr_t'({op, 2'd1, 2'd2, low});
		id.rs_val = rs;
		id.rt_val = rt;
		return id;
	endfunction

	// Overflow corners and one case of each immediate, branch and jump form
	task automatic load_directed();
		directed.push_back(build_instr(4'd15, 8'hc0, 16'h0010, 16'h7fff, 16'h0001));
		directed.push_back(build_instr(4'd15, 8'hc0, 16'h0011, 16'h8000, 16'hffff));
		directed.push_back(build_instr(4'd15, 8'hc0, 16'h0012, 16'h7ffe, 16'h0001));
		directed.push_back(build_instr(4'd15, 8'hc1, 16'h0013, 16'h8000, 16'h0001));
		directed.push_back(build_instr(4'd15, 8'hc1, 16'h0014, 16'h7fff, 16'hffff));
		directed.push_back(build_instr(4'd15, 8'hc1, 16'h0015, 16'h0000, 16'h8000));
		directed.push_back(build_instr(4'd15, 8'hc1, 16'h0016, 16'hffff, 16'h8000));
		directed.push_back(build_instr(4'd4, 8'h01, 16'h0017, 16'h7fff, 16'h0000));
		directed.push_back(build_instr(4'd4, 8'hff, 16'h0018, 16'h8000, 16'h0000));
		directed.push_back(build_instr(4'd7, 8'h80, 16'h0019, 16'h1000, 16'h0000));
		directed.push_back(build_instr(4'd8, 8'h7f, 16'h001a, 16'h1000, 16'hbeef));
		directed.push_back(build_instr(4'd5, 8'hf0, 16'h001b, 16'h1200, 16'h0000));
		directed.push_back(build_instr(4'd6, 8'ha5, 16'h001c, 16'h0000, 16'h0000));
		directed.push_back(build_instr(4'd1, 8'hfc, 16'h0100, 16'h1234, 16'h1234));
		directed.push_back(build_instr(4'd0, 8'h05, 16'h0101, 16'h1234, 16'h1234));
		directed.push_back(build_instr(4'd2, 8'h10, 16'h0102, 16'h0000, 16'h0000));
		directed.push_back(build_instr(4'd3, 8'h10, 16'h0103, 16'h8000, 16'h0000));
		directed.push_back(build_instr(4'd9, 8'h34, 16'ha123, 16'h0000, 16'h0000));
		directed.push_back(build_instr(4'd15, 8'h1a, 16'h0200, 16'h4321, 16'h0000));
		directed.push_back(build_instr(4'd15, 8'h1d, 16'h0201, 16'h5555, 16'h0000));
		directed.push_back(build_instr(4'd12, 8'h33, 16'h0202, 16'h5555, 16'h0000));
	endtask

	task automatic random_instr(output id_ex_t id);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [3:0]  op;
		logic [7:0]  low;
		logic [15:0] corners [0:3];
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		corners = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff};
		// Half the draws are register operations and the rest spread over all 16 opcodes
		op = r1[4] ? 4'd15 : r1[3:0];
		low = (op == 4'd15) ? {r1[6:5], func_pool[r1[11:8]]} : r1[15:8];
		id = build_instr(op, low, r2[15:0], r2[31:16], r3[15:0]);
		if (r1[18:17] == 2'd0)
			id.rs_val = corners[r1[20:19]];
		if (r1[21])
			id.rt_val = id.rs_val;
		id.valid = r1[24:22] != 3'd0;
	endtask

	// Tracks what the DUT captured at this edge
	always @(posedge clk) begin
		clocked = 1'b1;
		rst_edge = rst;
		ex_new = !rst && !stall;
		if (rst) begin
			idex_valid_m = 1'b0;
		end else if (!stall) begin
			edge_count = edge_count + 1;
			idex_m = id_in;
			idex_valid_m = id_in.valid;
			if (id_in.valid) begin
				exp_q.push_back(exec_ref(id_in));
				issue_q.push_back(edge_count);
			end
		end
	end

	always @(negedge clk) begin
		ex_mem_t exp;
		ex_mem_t br;
		logic    due;
		if (exp_q.size() > 0 && issue_q[0] < edge_count - 1)
			report_problem("An issued instruction never reached ex_out");
		if (ex_new || rst_edge) begin
			due = ex_new && exp_q.size() > 0 && issue_q[0] == edge_count - 1;
			assert (ex_out.valid == due)
				else report_mismatch("ex_out.valid", 16'(ex_out.valid), 16'(due));
			if (due) begin
				exp = exp_q.pop_front();
				void'(issue_q.pop_front());
				assert (ex_out.instr == exp.instr)
					else report_mismatch("ex_out.instr", ex_out.instr, exp.instr);
				assert (ex_out.result == exp.result)
					else report_mismatch("ex_out.result", ex_out.result, exp.result);
				assert (ex_out.overflow == exp.overflow)
					else report_mismatch("ex_out.overflow", 16'(ex_out.overflow),
						16'(exp.overflow));
				assert (ex_out.store_data == exp.store_data)
					else report_mismatch("ex_out.store_data", ex_out.store_data,
						exp.store_data);
				assert (ex_out.redirect == exp.redirect)
					else report_mismatch("ex_out.redirect", 16'(ex_out.redirect),
						16'(exp.redirect));
				assert (ex_out.next_pc == exp.next_pc)
					else report_mismatch("ex_out.next_pc", ex_out.next_pc, exp.next_pc);
			end
		end
		if (idex_valid_m) begin
			br = exec_ref(idex_m);
			assert (redirect == br.redirect)
				else report_mismatch("redirect", 16'(redirect), 16'(br.redirect));
			assert (next_pc == br.next_pc)
				else report_mismatch("next_pc", next_pc, br.next_pc);
		end else if (clocked) begin
			assert (!redirect) else report_mismatch("redirect", 16'(redirect), 16'h0);
		end
	end

	initial begin
		id_ex_t      next_id;
		int          issued;
		int          cycles;
		int          drain;
		logic [31:0] r;
		seed = 32'h50f7_cf33;
		rst = 1'b1;
		stall = 1'b0;
		id_in = '0;
		load_directed();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		issued = 0;
		cycles = 0;
		while (issued < NUM_INSTR && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
			r = $random(seed);
			// A held instruction is replaced only once the DUT has taken it
			if (!stall) begin
				if (id_in.valid)
					issued++;
				if (issued >= NUM_INSTR)
					next_id = '0;
				else if (directed.size() > 0)
					next_id = directed.pop_front();
				else
					random_instr(next_id);
				id_in <= next_id;
			end
			stall <= (issued < NUM_INSTR) && (r[1:0] == 2'd0);
		end
		if (issued < NUM_INSTR) begin
			report_problem("Stimulus did not finish within the cycle limit");
		end else begin
			drain = 0;
			while (exp_q.size() > 0 && drain < DRAIN_LIMIT) begin
				@(posedge clk);
				drain++;
			end
			if (exp_q.size() > 0) begin
				report_problem("Instructions still outstanding after the drain timeout");
			end else begin
				$display("All checks passed");
				$finish;
			end
		end
	end

endmodule

// File: tsc_config.svh
`ifndef TSC_CONFIG_SVH
`define TSC_CONFIG_SVH

// Data and address words share one width
`define WORD_SIZE 16
`define REG_ADDR_W 2
`define IMM_W 8
`define JTARGET_W 12

`endif
